/* Makefile */
SIM      := verilator
FLAGS    := --binary --assert -j 0
TOP      := tb_spinn_link_receiver
FILELIST := sim.f
LOG      := sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* rtl/flit_acceptor.sv */
/* link front end: synchronises the 2-of-7 nrz wires, turns each new symbol
   into its rtz form (the wires that changed) and toggles the ack when the
   assembler takes it; also sends the single ack on reset exit */
`timescale 1ns/1ps
module flit_acceptor (
  input  logic                 CLK_IN,
  input  logic                 RESET_IN,
  input  spinn_link_pkg::sym_t link_data,  // async nrz wires
  output logic                 link_ack,   // toggle per symbol
  output spinn_link_pkg::sym_t sym,        // rtz symbol
  output logic                 sym_vld,
  input  logic                 sym_rdy
);
  import spinn_link_pkg::*;

  sym_t sync_1;    // first flop, may go metastable
  sym_t sync_2;    // safe copy of the wires
  sym_t last_nrz;  // wire value of last accepted symbol
  sym_t nrz_next;
  sym_t rtz_next;
  logic start_q;   // first cycle after reset
  logic accept;

  // ------------------------------
  // two-flop synchroniser
  // ------------------------------
  always_ff @(posedge CLK_IN) begin
    sync_1 <= link_data;
    sync_2 <= sync_1;
  end

  assign accept = sym_vld && sym_rdy;

  // reference value for the next rtz symbol
  always_comb begin
    if (start_q) begin
      nrz_next = sync_2;  // take whatever the wires idle at
    end else if (accept) begin
      nrz_next = last_nrz ^ sym;  // nrz value that formed the taken symbol
    end else begin
      nrz_next = last_nrz;
    end
  end

  assign rtz_next = sync_2 ^ nrz_next;  // changed wires only

  // symbol register, compared against the updated reference
  // so a taken symbol never shows twice
  always_ff @(posedge CLK_IN) begin
    last_nrz <= nrz_next;
    sym      <= rtz_next;
  end

  // ------------------------------
  // control and ack
  // ------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      start_q  <= 1'b1;
      sym_vld  <= 1'b0;
      link_ack <= 1'b0;
    end else begin
      start_q <= 1'b0;
      // single-wire change is a skewed symbol still arriving
      sym_vld <= ($countones(rtz_next) >= 2);
      if (start_q || accept) begin
        link_ack <= ~link_ack;  // reset-exit ack, then one per symbol
      end
    end
  end

  // the transmitter counts acks, so a stray toggle loses a symbol
  a_ack_toggle: assert property (@(posedge CLK_IN) disable iff (RESET_IN)
    $changed(link_ack) |-> $past(start_q || accept));

endmodule

/* rtl/packet_assembler.sv */
/* packet FSM: collects decoded nibbles into short or long packets, checks
   the flit count at end-of-packet, flags flit and frame errors and holds
   one finished packet on the valid/ready output */
`timescale 1ns/1ps
module packet_assembler (
  input  logic                                CLK_IN,
  input  logic                                RESET_IN,
  input  logic                                sym_vld,
  output logic                                sym_rdy,
  input  logic                                is_data,
  input  logic                                is_eop,
  input  logic                                is_bad,
  input  spinn_link_pkg::nib_t                nibble,
  output logic [spinn_link_pkg::PKT_BITS-1:0] pkt_data,
  output logic                                pkt_vld,
  input  logic                                pkt_rdy,
  output logic                                flt_err,
  output logic                                frm_err
);
  import spinn_link_pkg::*;

  pkt_state_e                state;
  logic [FLIT_CNT_BITS-1:0] flit_cnt;  // nibbles so far
  logic                     long_pkt;  // payload expected
  logic [PKT_BITS-1:0]      pkt_buf;   // shift buffer, newest at top
  spinn_pkt_u               pkt_q;     // output register
  logic                     accept;
  logic                     pkt_busy;  // output full and not read
  logic                     exp_eop;   // count matches packet length
  logic                     collecting;
  logic                     load_pkt;

  assign accept     = sym_vld && sym_rdy;
  assign pkt_busy   = pkt_vld && !pkt_rdy;
  assign collecting = (state == ST_IDLE) || (state == ST_TRANSFER);
  assign exp_eop    = long_pkt ? (flit_cnt == FLIT_CNT_BITS'(LONG_FLITS))
                               : (flit_cnt == FLIT_CNT_BITS'(SHORT_FLITS));

  // good eop with room, or a held packet finally getting room
  assign load_pkt = ((state == ST_TRANSFER) && accept && is_eop && exp_eop && !pkt_busy)
                 || ((state == ST_WAIT) && !pkt_busy);

  assign sym_rdy  = (state != ST_START) && (state != ST_WAIT);  // stall link in wait
  assign pkt_data = pkt_q.raw;

  // ------------------------------
  // state machine
  // ------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      state <= ST_START;
    end else begin
      case (state)
        ST_START: state <= ST_IDLE;
        ST_IDLE: begin
          if (accept && is_data) begin
            state <= ST_TRANSFER;  // header nibble
          end else if (accept && is_bad) begin
            state <= ST_DROP;
          end
        end
        ST_TRANSFER: begin
          if (accept && is_bad) begin
            state <= ST_DROP;
          end else if (accept && is_eop) begin
            if (exp_eop && pkt_busy) begin
              state <= ST_WAIT;  // hold pkt in buffer
            end else begin
              state <= ST_IDLE;  // sent, or dropped on frame error
            end
          end
        end
        ST_WAIT: begin
          if (!pkt_busy) begin
            state <= ST_IDLE;
          end
        end
        ST_DROP: begin
          if (accept && is_eop) begin
            state <= ST_IDLE;  // rest of bad pkt gone
          end
        end
        default: state <= ST_DROP;
      endcase
    end
  end

  // ------------------------------
  // flit count and packet length
  // ------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      flit_cnt <= '0;
      long_pkt <= 1'b0;
    end else if (accept && is_data) begin
      if (state == ST_IDLE) begin
        flit_cnt <= FLIT_CNT_BITS'(1);
        long_pkt <= nibble[HDR_LONG_BIT];  // first nibble is header[3:0]
      end else if ((state == ST_TRANSFER) && (flit_cnt != '1)) begin
        flit_cnt <= flit_cnt + 1'b1;  // saturates, late eop still caught
      end
    end
  end

  // buffer and output word, no reset needed
  always_ff @(posedge CLK_IN) begin
    if (accept && is_data && collecting) begin
      pkt_buf <= {nibble, pkt_buf[PKT_BITS-1:NIB_BITS]};
    end
    if (load_pkt) begin
      // short pkt sits in the top 40 bits, bring it down
      pkt_q.raw <= long_pkt ? pkt_buf : (pkt_buf >> PAYLOAD_BITS);
    end
  end

  // ------------------------------
  // output valid and error pulses
  // ------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      pkt_vld <= 1'b0;
      flt_err <= 1'b0;
      frm_err <= 1'b0;
    end else begin
      if (load_pkt) begin
        pkt_vld <= 1'b1;
      end else if (pkt_rdy) begin
        pkt_vld <= 1'b0;  // taken
      end
      flt_err <= accept && is_bad && collecting;
      // stray eop in idle counts as a zero-length frame
      frm_err <= accept && is_eop && ((state == ST_IDLE) || ((state == ST_TRANSFER) && !exp_eop));
    end
  end

  a_pkt_hold: assert property (@(posedge CLK_IN) disable iff (RESET_IN)
    pkt_vld && !pkt_rdy |=> pkt_vld && $stable(pkt_data));

  a_vld_reset: assert property (@(posedge CLK_IN)
    $fell(RESET_IN) |-> !pkt_vld);

endmodule

/* rtl/spinn_link_pkg.sv */
/* widths, 2-of-7 symbol codes and packet types for the SpiNNaker link receiver
   imported by every receiver block and by the testbench encoder */
package spinn_link_pkg;

  // ------------------------------
  // widths and packet lengths
  // ------------------------------
  localparam int SYM_BITS      = 7;   // one wire per symbol bit
  localparam int NIB_BITS      = 4;   // data carried per flit
  localparam int PKT_BITS      = 72;
  localparam int HDR_BITS      = 8;
  localparam int KEY_BITS      = 32;
  localparam int PAYLOAD_BITS  = 32;
  localparam int SHORT_FLITS   = 10;  // header + key
  localparam int LONG_FLITS    = 18;  // header + key + payload
  localparam int FLIT_CNT_BITS = $clog2(LONG_FLITS + 1);
  localparam int HDR_LONG_BIT  = 1;   // header bit flagging a payload

  typedef logic [SYM_BITS-1:0] sym_t;  // nrz or rtz symbol
  typedef logic [NIB_BITS-1:0] nib_t;

  // ------------------------------
  // rtz symbol codes
  // ------------------------------
  localparam sym_t EOP_CODE = 7'b1100000;

  localparam sym_t NIB_CODE [2**NIB_BITS] = '{
    7'b0010001, 7'b0010010, 7'b0010100, 7'b0011000,  // 0..3
    7'b0100001, 7'b0100010, 7'b0100100, 7'b0101000,  // 4..7
    7'b1000001, 7'b1000010, 7'b1000100, 7'b1001000,  // 8..11
    7'b0000011, 7'b0000110, 7'b0001100, 7'b0001001   // 12..15
  };

  // one packet word, seen whole or split into its fields
  typedef union packed {
    logic [PKT_BITS-1:0] raw;
    struct packed {
      logic [PAYLOAD_BITS-1:0] payload;  // long packets only
      logic [KEY_BITS-1:0]     key;
      logic [HDR_BITS-1:0]     header;   // first flits on the wire
    } fields;
  } spinn_pkt_u;

  // assembler states
  typedef enum logic [2:0] {
    ST_START,     // one cycle after reset
    ST_IDLE,      // waiting for first nibble
    ST_TRANSFER,  // collecting nibbles
    ST_WAIT,      // finished pkt, output still full
    ST_DROP       // discard up to next eop
  } pkt_state_e;

endpackage

/* rtl/spinn_link_receiver.sv */
/* SpiNNaker link receiver top: 2-of-7 toggle-ack link in, assembled packets
   out on valid/ready, plus flit and frame error pulses */
`timescale 1ns/1ps
module spinn_link_receiver (
  input  logic                                CLK_IN,
  input  logic                                RESET_IN,
  input  spinn_link_pkg::sym_t                link_data,
  output logic                                link_ack,
  output logic [spinn_link_pkg::PKT_BITS-1:0] pkt_data,
  output logic                                pkt_vld,
  input  logic                                pkt_rdy,
  output logic                                flt_err,
  output logic                                frm_err
);
  import spinn_link_pkg::*;

  sym_t sym;      // rtz symbol from the acceptor
  logic sym_vld;
  logic sym_rdy;
  logic is_data;
  logic is_eop;
  logic is_bad;
  nib_t nibble;

  // ------------------------------
  // link side
  // ------------------------------
  flit_acceptor u_acceptor (
    .CLK_IN    (CLK_IN),
    .RESET_IN  (RESET_IN),
    .link_data (link_data),
    .link_ack  (link_ack),
    .sym       (sym),
    .sym_vld   (sym_vld),
    .sym_rdy   (sym_rdy)
  );

  symbol_decoder_2of7 u_decoder (
    .sym     (sym),
    .is_data (is_data),
    .is_eop  (is_eop),
    .is_bad  (is_bad),
    .nibble  (nibble)
  );

  // ------------------------------
  // packet side
  // ------------------------------
  packet_assembler u_assembler (
    .CLK_IN   (CLK_IN),
    .RESET_IN (RESET_IN),
    .sym_vld  (sym_vld),
    .sym_rdy  (sym_rdy),
    .is_data  (is_data),
    .is_eop   (is_eop),
    .is_bad   (is_bad),
    .nibble   (nibble),
    .pkt_data (pkt_data),
    .pkt_vld  (pkt_vld),
    .pkt_rdy  (pkt_rdy),
    .flt_err  (flt_err),
    .frm_err  (frm_err)
  );

endmodule

/* rtl/symbol_decoder_2of7.sv */
/* purely combinational 2-of-7 classifier
   sorts one rtz symbol into data nibble, end-of-packet or bad symbol */
`timescale 1ns/1ps
module symbol_decoder_2of7 (
  input  spinn_link_pkg::sym_t sym,
  output logic                 is_data,
  output logic                 is_eop,
  output logic                 is_bad,
  output spinn_link_pkg::nib_t nibble
);
  import spinn_link_pkg::*;

  logic two_plus;  // enough wires changed to be a symbol

  // ------------------------------
  // nibble lookup
  // ------------------------------
  always_comb begin
    nibble  = '0;
    is_data = 1'b0;
    for (int i = 0; i < 2**NIB_BITS; i++) begin
      if (sym == NIB_CODE[i]) begin
        nibble  = nib_t'(i);
        is_data = 1'b1;
      end
    end
  end

  assign is_eop   = (sym == EOP_CODE);
  assign two_plus = ($countones(sym) >= 2);

  // anything else with 2+ changes is corruption,
  // e.g. two data wires of the same group or 3 wires
  assign is_bad = two_plus && !is_data && !is_eop;

  // ------------------------------
  // checks
  // ------------------------------
  // nib table and eop code live apart, an overlap would double-classify
  always_comb begin
    if (!$isunknown(sym)) begin
      a_one_class: assert ($onehot0({is_data, is_eop, is_bad}))
        else $error("2-of-7 symbol %b has more than one class", sym);
    end
  end

endmodule

/* sim.f */
rtl/spinn_link_pkg.sv
rtl/flit_acceptor.sv
rtl/symbol_decoder_2of7.sv
rtl/packet_assembler.sv
rtl/spinn_link_receiver.sv
verification/tb_spinn_link_receiver.sv

/* verification/link_stim.txt */
// kind (1 short, 2 long, 3 bad symbol, 4 early eop)   nibbles, nibble 0 rightmost
// fault position in hex   expected word, or error kind (1 flit, 2 frame)
1 00000000DEADBEEF41 00 00000000DEADBEEF41
2 123456789ABCDEF052 00 123456789ABCDEF052
3 00000000CAFEF00D01 04 000000000000000001
1 000000000BADC0DE08 00 000000000BADC0DE08
4 000000001122334405 03 000000000000000002
2 FFFFFFFF00000000A6 00 FFFFFFFF00000000A6
3 0000000076543210C0 00 000000000000000001
3 0F1E2D3C4B5A697887 0F 000000000000000001
4 111111112222222233 0C 000000000000000002
1 000000000123456789 00 000000000123456789
2 A5A5A5A55A5A5A5A0E 00 A5A5A5A55A5A5A5A0E
1 0000000013579BDF24 00 0000000013579BDF24
2 FEDCBA98765432102B 00 FEDCBA98765432102B
1 0000000000000000FD 00 0000000000000000FD

/* verification/tb_spinn_link_receiver.sv */
/* testbench for the link receiver: replays the packets of the stim file over
   the 2-of-7 toggle-ack link and checks packets and error pulses at the far end */
`timescale 1ns/1ps
module tb_spinn_link_receiver;
  import spinn_link_pkg::*;

  localparam int          NUM_PKTS    = 14;   // lines in the stim file
  localparam int          ACK_TIMEOUT = 400;  // in cycles, above the longest sink stall
  localparam int          ERR_TIMEOUT = 50;
  localparam int          K_SHORT     = 1;    // packet kinds in the stim file
  localparam int          K_LONG      = 2;
  localparam int          K_BAD       = 3;
  localparam int          K_EARLY     = 4;
  localparam int          E_FLIT      = 1;    // expected error kinds
  localparam int          E_FRAME     = 2;
  localparam sym_t        BAD_CODE    = 7'b0110000;  // two wires, matches no code
  localparam logic [31:0] SEED        = 32'he5aee319;

  logic                CLK_IN;
  logic                RESET_IN;
  sym_t                link_data;
  logic                link_ack;
  logic [PKT_BITS-1:0] pkt_data;
  logic                pkt_vld;
  logic                pkt_rdy;
  logic                flt_err;
  logic                frm_err;

  logic [PKT_BITS-1:0] stim_mem [NUM_PKTS*4];  // 4 words per packet
  spinn_pkt_u          exp_q [$];              // good packets still due
  sym_t                tx_nrz;                 // wire levels being driven
  logic                ack_seen;               // last link_ack level seen
  logic [31:0]         gap_st = SEED;          // lfsr for symbol gaps
  logic [31:0]         rdy_st = SEED;          // lfsr for sink stalls
  logic                took = 1'b0;            // sink just took a packet
  int                  flt_cnt = 0;
  int                  frm_cnt = 0;
  int                  flt_want = 0;
  int                  frm_want = 0;

  spinn_link_receiver dut (
    .CLK_IN    (CLK_IN),
    .RESET_IN  (RESET_IN),
    .link_data (link_data),
    .link_ack  (link_ack),
    .pkt_data  (pkt_data),
    .pkt_vld   (pkt_vld),
    .pkt_rdy   (pkt_rdy),
    .flt_err   (flt_err),
    .frm_err   (frm_err)
  );

  initial begin
    CLK_IN = 1'b0;
    forever #20 CLK_IN = ~CLK_IN;  // 40 ns period
  end

  // ------------------------------
  // helpers and compare tasks
  // ------------------------------
  task automatic stop_run();
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_pkt(input spinn_pkt_u got, input spinn_pkt_u want);
    if ((got.fields.header !== want.fields.header) || (got.fields.key !== want.fields.key)
        || (got.fields.payload !== want.fields.payload)) begin
      $display("FAILED at time %0t: packet hdr %h key %h pay %h, expected hdr %h key %h pay %h",
               $time, got.fields.header, got.fields.key, got.fields.payload,
               want.fields.header, want.fields.key, want.fields.payload);
      stop_run();
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic want);
    if (got !== want) begin
      $display("FAILED at time %0t: %s is %b, expected %b", $time, what, got, want);
      stop_run();
    end
  endtask

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(inout logic [31:0] st, input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      st  = lfsr_next(st);  // one step per bit
      val = (val << 1) | int'(st[0]);
    end
  endtask

  task automatic next_cycle();
    @(posedge CLK_IN);
    #1;  // inputs move just after the edge
  endtask

  // ------------------------------
  // link transmitter model
  // ------------------------------
  task automatic send_sym(input sym_t rtz);
    int gap;
    int n;
    draw_bits(gap_st, 2, gap);
    repeat (gap) next_cycle();   // idle gap 0..3 cycles
    tx_nrz    = tx_nrz ^ rtz;    // nrz flips the two wires of the code
    link_data = tx_nrz;
    n = 0;
    while ((link_ack === ack_seen) && (n < ACK_TIMEOUT)) begin
      next_cycle();
      n++;
    end
    if (link_ack === ack_seen) begin
      $display("timed out waiting for the link_ack toggle after symbol %b", rtz);
      stop_run();
    end
    ack_seen = link_ack;
  endtask

  task automatic send_packet(input int idx);
    int                  kind;
    logic [PKT_BITS-1:0] nibs;
    int                  pos;      // fault position
    int                  n_flits;
    spinn_pkt_u          want;
    int                  flt0;
    int                  frm0;
    int                  n;
    kind     = int'(stim_mem[4*idx][3:0]);
    nibs     = stim_mem[4*idx+1];
    pos      = int'(stim_mem[4*idx+2][7:0]);
    want.raw = stim_mem[4*idx+3];
    flt0     = flt_cnt;
    frm0     = frm_cnt;
    // header bit 1 rides in the first nibble and sets the length
    n_flits  = nibs[HDR_LONG_BIT] ? LONG_FLITS : SHORT_FLITS;
    if (kind == K_EARLY) begin
      n_flits = pos;  // eop takes the place of flit pos
    end
    if ((kind == K_SHORT) || (kind == K_LONG)) begin
      exp_q.push_back(want);
    end
    for (int i = 0; i < n_flits; i++) begin
      if ((kind == K_BAD) && (i == pos)) begin
        send_sym(BAD_CODE);
      end else begin
        send_sym(NIB_CODE[nibs[4*i +: 4]]);
      end
    end
    send_sym(EOP_CODE);
    if ((kind == K_BAD) || (kind == K_EARLY)) begin
      flt_want += (want.raw == PKT_BITS'(E_FLIT)) ? 1 : 0;
      frm_want += (want.raw == PKT_BITS'(E_FRAME)) ? 1 : 0;
      next_cycle();  // pulse of the eop itself gets counted
      n = 0;
      while ((flt_cnt == flt0) && (frm_cnt == frm0) && (n < ERR_TIMEOUT)) begin
        next_cycle();
        n++;
      end
      if ((flt_cnt == flt0) && (frm_cnt == frm0)) begin
        $display("timed out waiting for an error pulse on stim packet %0d", idx);
        stop_run();
      end
      check_flag("flt_err pulse", flt_cnt != flt0, want.raw == PKT_BITS'(E_FLIT));
      check_flag("frm_err pulse", frm_cnt != frm0, want.raw == PKT_BITS'(E_FRAME));
    end
  endtask

  // ------------------------------
  // packet sink and monitors
  // ------------------------------
  always @(negedge CLK_IN) begin : sink_monitor
    spinn_pkt_u got;
    if (!RESET_IN) begin
      if (flt_err === 1'b1) flt_cnt++;  // each high cycle counts
      if (frm_err === 1'b1) frm_cnt++;
      if (pkt_vld && pkt_rdy) begin     // taken at the next rising edge
        if (exp_q.size() == 0) begin
          $display("a packet came out when none was expected");
          stop_run();
        end else begin
          got.raw = pkt_data;
          check_pkt(got, exp_q.pop_front());
          took = 1'b1;
        end
      end
    end
  end

  // random stall of 0..127 cycles after each taken packet
  initial begin : rdy_driver
    int stall;
    stall = 0;
    forever begin
      next_cycle();
      if (took) begin
        took = 1'b0;
        draw_bits(rdy_st, 7, stall);
      end
      if (stall > 0) begin
        pkt_rdy = 1'b0;
        stall--;
      end else begin
        pkt_rdy = 1'b1;
      end
    end
  end

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin : main_seq
    int n;
    RESET_IN  = 1'b1;
    link_data = '0;
    pkt_rdy   = 1'b0;
    tx_nrz    = '0;  // wires idle low
    ack_seen  = 1'b0;
    $readmemh("verification/link_stim.txt", stim_mem);
    repeat (5) next_cycle();
    check_flag("link_ack in reset", link_ack, 1'b0);
    check_flag("pkt_vld in reset", pkt_vld, 1'b0);
    RESET_IN = 1'b0;
    n = 0;
    while ((link_ack !== 1'b1) && (n < ACK_TIMEOUT)) begin
      next_cycle();
      n++;
    end
    if (link_ack !== 1'b1) begin
      $display("timed out waiting for the reset-exit link_ack");
      stop_run();
    end
    ack_seen = link_ack;
    repeat (8) begin  // nothing may move on a quiet link
      next_cycle();
      check_flag("link_ack before first symbol", link_ack, ack_seen);
      check_flag("pkt_vld before first symbol", pkt_vld, 1'b0);
      check_flag("flt_err before first symbol", flt_err, 1'b0);
      check_flag("frm_err before first symbol", frm_err, 1'b0);
    end
    for (int i = 0; i < NUM_PKTS; i++) begin
      send_packet(i);
    end
    n = 0;
    while (((exp_q.size() != 0) || pkt_vld) && (n < ACK_TIMEOUT)) begin
      next_cycle();
      n++;
    end
    if (exp_q.size() != 0) begin
      $display("timed out with %0d packets never delivered", exp_q.size());
      stop_run();
    end
    if ((flt_cnt == flt_want) && (frm_cnt == frm_want)) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      $display("FAILED at time %0t: %0d flit and %0d frame error pulses, expected %0d and %0d",
               $time, flt_cnt, frm_cnt, flt_want, frm_want);
      stop_run();
    end
  end

endmodule
